//--- tcp_conn_pkg.sv
package tcp_conn_pkg;

  typedef logic [15:0] tcp_port_t;
  typedef logic [31:0] tcp_num_t;
  typedef logic [15:0] tcp_wnd_t;
  typedef logic [3:0]  tcp_scl_t; // window scale shift, legal range 0..14

  // flag bits in header order, msb first
  typedef struct packed {
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flag_bits_t;

  typedef union packed {
    logic [7:0]     raw;  // whole byte, for exact matches
    tcp_flag_bits_t bits; // single flags
  } tcp_flags_u;

  localparam logic [7:0] TCP_FLAG_FIN = 8'h01;
  localparam logic [7:0] TCP_FLAG_SYN = 8'h02;
  localparam logic [7:0] TCP_FLAG_RST = 8'h04;
  localparam logic [7:0] TCP_FLAG_ACK = 8'h10;

  localparam tcp_scl_t MAX_WND_SCL = 4'd14;

  typedef struct packed {
    tcp_port_t  src_port;
    tcp_port_t  dst_port;
    tcp_num_t   seq_num;
    tcp_num_t   ack_num;
    tcp_flags_u flags;
    tcp_wnd_t   wnd;
    logic       scl_pres; // window scale option present
    tcp_scl_t   scl;
    logic [15:0] pld_len;
  } tcp_seg_t;

  typedef struct packed {
    logic     val;
    tcp_seg_t seg;
  } tcp_seg_strb_t;

  typedef struct packed {
    logic      listen;
    logic      connect;
    tcp_port_t loc_port;
    tcp_port_t rem_port;
  } tcp_ctl_t;

  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } tcp_status_e;

  // connection state as seen by the datapath
  typedef struct packed {
    tcp_port_t   loc_port;
    tcp_port_t   rem_port;
    tcp_num_t    loc_seq;
    tcp_num_t    loc_ack;
    tcp_num_t    rem_ack;
    logic [31:0] rem_wnd;
  } tcp_tcb_t;

  // same field order as tcp_tcb_t, status in front
  typedef struct packed {
    tcp_status_e status;
    tcp_port_t   loc_port;
    tcp_port_t   rem_port;
    tcp_num_t    loc_seq;
    tcp_num_t    loc_ack;
    tcp_num_t    rem_ack;
    logic [31:0] rem_wnd;
  } tcp_info_t;

  typedef struct packed {
    logic     loc_port_hit;
    logic     conn_hit;
    logic     syn;
    logic     syn_ack;
    logic     ack;
    logic     ack_ok;
    logic     fin;
    logic     rst;
    tcp_seg_t seg;
  } tcp_evt_t;

  typedef enum logic [2:0] {
    send_none,
    send_syn,
    send_syn_ack,
    send_ack,
    send_fin_ack,
    send_rst_ack
  } send_kind_e;

  typedef enum logic [2:0] {
    op_none,
    op_open_active,
    op_open_passive,
    op_syn_ack_rec,
    op_ack_rec,
    op_fin_ack_inc,
    op_update
  } tcb_op_e;

endpackage

//--- tcp_conn_timer.sv
`timescale 1ns/1ps

module tcp_conn_timer #(
  parameter int TIMEOUT_TICKS = 1000
) (
  input  logic clk,
  input  logic rst_rec,
  input  logic run,
  output logic exp
);

  localparam int CW = $clog2(TIMEOUT_TICKS + 1);

  logic [CW-1:0] cnt;

  // counter stops at TIMEOUT_TICKS so exp fires only once per run
  always_ff @(posedge clk) begin
    if (rst_rec || !run) begin
      cnt <= '0;
      exp <= 1'b0;
    end else begin
      exp <= (cnt == CW'(TIMEOUT_TICKS - 1));
      if (cnt != CW'(TIMEOUT_TICKS)) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

//--- tcp_seg_classify.sv
`timescale 1ns/1ps

module tcp_seg_classify (
  input  logic                        clk,
  input  logic                        rst_rec,
  input  tcp_conn_pkg::tcp_seg_strb_t rx_seg,
  input  tcp_conn_pkg::tcp_port_t     loc_port,
  input  tcp_conn_pkg::tcp_tcb_t      tcb,
  output tcp_conn_pkg::tcp_evt_t      evt
);
  import tcp_conn_pkg::*;

  logic       val_q;
  tcp_seg_t   seg_q;
  tcp_flags_u fl;
  tcp_num_t   ack_exp;

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      val_q <= 1'b0;
    end else begin
      val_q <= rx_seg.val;
    end
  end

  // header holds until the next segment
  always_ff @(posedge clk) begin
    if (rx_seg.val) begin
      seg_q <= rx_seg.seg;
    end
  end

  assign fl      = seg_q.flags;
  assign ack_exp = tcb.loc_seq + 32'd1; // what the peer must ack for our SYN or FIN

  ////////////////////////////////////////////////////////////
  // events, valid for one cycle
  assign evt.loc_port_hit = val_q && (seg_q.dst_port == loc_port);
  assign evt.conn_hit     = val_q && (seg_q.dst_port == tcb.loc_port)
                                  && (seg_q.src_port == tcb.rem_port);
  assign evt.syn          = val_q && (fl.raw == TCP_FLAG_SYN); // bare SYN only
  assign evt.syn_ack      = val_q && fl.bits.syn && fl.bits.ack;
  assign evt.ack          = val_q && fl.bits.ack;
  assign evt.ack_ok       = val_q && (seg_q.ack_num == ack_exp);
  assign evt.fin          = val_q && fl.bits.fin;
  assign evt.rst          = val_q && fl.bits.rst;
  assign evt.seg          = seg_q;

endmodule

//--- tcp_tcb_reg.sv
`timescale 1ns/1ps

module tcp_tcb_reg #(
  parameter logic [31:0] ISN_POLY = 32'hdeadbeef
) (
  input  logic                   clk,
  input  logic                   rst_rec,
  input  tcp_conn_pkg::tcp_ctl_t ctl,
  input  tcp_conn_pkg::tcp_evt_t evt,
  input  tcp_conn_pkg::tcb_op_e  tcb_op,
  output tcp_conn_pkg::tcp_tcb_t tcb
);
  import tcp_conn_pkg::*;

  tcp_seg_t    seg;
  tcp_num_t    isn;        // free running lfsr
  tcp_scl_t    rem_scl;    // peer window shift
  tcp_scl_t    seg_scl;
  tcp_num_t    ack_dif;
  logic [31:0] wnd_scaled;

  assign seg = evt.seg;

  // option value capped at 14, no option means no scaling
  assign seg_scl    = !seg.scl_pres ? '0 :
                      (seg.scl > MAX_WND_SCL) ? MAX_WND_SCL : seg.scl;
  assign ack_dif    = seg.ack_num - tcb.rem_ack;
  assign wnd_scaled = {16'd0, seg.wnd} << rem_scl;

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      isn <= 32'd1;
    end else begin
      isn <= isn[0] ? ((isn >> 1) ^ ISN_POLY) : (isn >> 1);
    end
  end

  ////////////////////////////////////////////////////////////
  // tcb updates, one op per cycle
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      tcb     <= '0;
      rem_scl <= '0;
    end else begin
      case (tcb_op)
        op_open_active : begin
          tcb.loc_port <= ctl.loc_port;
          tcb.rem_port <= ctl.rem_port;
          tcb.loc_seq  <= isn;
          tcb.loc_ack  <= '0; // unknown until SYN-ACK
          tcb.rem_ack  <= '0;
          tcb.rem_wnd  <= '0;
          rem_scl      <= '0;
        end
        op_open_passive : begin
          tcb.loc_port <= ctl.loc_port;
          tcb.rem_port <= seg.src_port;
          tcb.loc_seq  <= isn;
          tcb.loc_ack  <= seg.seq_num + 32'd1;
          tcb.rem_ack  <= seg.ack_num;
          tcb.rem_wnd  <= {16'd0, seg.wnd}; // SYN window is never scaled
          rem_scl      <= seg_scl;
        end
        op_syn_ack_rec : begin
          tcb.loc_seq <= tcb.loc_seq + 32'd1; // our SYN consumed
          tcb.loc_ack <= seg.seq_num + 32'd1;
          tcb.rem_ack <= seg.ack_num;
          tcb.rem_wnd <= {16'd0, seg.wnd};
          rem_scl     <= seg_scl;
        end
        op_ack_rec : begin
          tcb.loc_seq <= tcb.loc_seq + 32'd1;
          tcb.rem_ack <= seg.ack_num;
          tcb.rem_wnd <= wnd_scaled;
        end
        op_fin_ack_inc : tcb.loc_ack <= tcb.loc_ack + 32'd1;
        op_update : begin
          // remote ack only moves forward, modulo 2^32
          if (!ack_dif[31] && (ack_dif != '0)) tcb.rem_ack <= seg.ack_num;
          tcb.rem_wnd <= wnd_scaled;
        end
        default : ;
      endcase
    end
  end

endmodule

//--- tcp_seg_build.sv
`timescale 1ns/1ps

module tcp_seg_build #(
  parameter int LOCAL_WND = 4000,
  parameter int LOCAL_SCL = 8
) (
  input  logic                        clk,
  input  logic                        rst_rec,
  input  tcp_conn_pkg::send_kind_e    send,
  input  tcp_conn_pkg::tcp_tcb_t      tcb,
  output tcp_conn_pkg::tcp_seg_strb_t tx_seg
);
  import tcp_conn_pkg::*;

  tcp_flags_u flags;
  logic       opt_pres; // window scale option goes out with SYN only
  logic       val_q;
  tcp_seg_t   seg_q;

  always_comb begin
    flags.raw = 8'h00;
    opt_pres  = 1'b0;
    case (send)
      send_syn : begin
        flags.raw = TCP_FLAG_SYN;
        opt_pres  = 1'b1;
      end
      send_syn_ack : begin
        flags.raw = TCP_FLAG_SYN | TCP_FLAG_ACK;
        opt_pres  = 1'b1;
      end
      send_ack     : flags.raw = TCP_FLAG_ACK;
      send_fin_ack : flags.raw = TCP_FLAG_FIN | TCP_FLAG_ACK;
      send_rst_ack : flags.raw = TCP_FLAG_RST | TCP_FLAG_ACK;
      default      : flags.raw = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      val_q <= 1'b0;
    end else begin
      val_q <= (send != send_none);
    end
  end

  ////////////////////////////////////////////////////////////
  // header fields, captured with the send strobe
  always_ff @(posedge clk) begin
    if (send != send_none) begin
      seg_q.src_port <= tcb.loc_port;
      seg_q.dst_port <= tcb.rem_port;
      seg_q.seq_num  <= tcb.loc_seq;
      seg_q.ack_num  <= (send == send_syn) ? '0 : tcb.loc_ack; // nothing to ack yet
      seg_q.flags    <= flags;
      seg_q.wnd      <= tcp_wnd_t'(LOCAL_WND);
      seg_q.scl_pres <= opt_pres;
      seg_q.scl      <= opt_pres ? tcp_scl_t'(LOCAL_SCL) : '0;
      seg_q.pld_len  <= '0; // headers only
    end
  end

  assign tx_seg.val = val_q;
  assign tx_seg.seg = seg_q;

endmodule

//--- tcp_conn_fsm.sv
`timescale 1ns/1ps

module tcp_conn_fsm (
  input  logic                      clk,
  input  logic                      rst_rec,
  input  tcp_conn_pkg::tcp_ctl_t    ctl,
  input  tcp_conn_pkg::tcp_evt_t    evt,
  input  logic                      tmr_exp,
  output tcp_conn_pkg::tcp_status_e status,
  output tcp_conn_pkg::send_kind_e  send,
  output tcp_conn_pkg::tcb_op_e     tcb_op,
  output logic                      tmr_run
);
  import tcp_conn_pkg::*;

  typedef enum logic [3:0] {
    closed_s,
    listen_s,
    send_syn_s,
    syn_sent_s,
    send_syn_ack_s,
    syn_ack_sent_s,
    send_ack_open_s,
    established_s,
    send_fin_s,
    fin_sent_s,
    send_last_ack_s,
    last_ack_sent_s,
    send_rst_s
  } state_e;

  typedef enum logic {
    tcp_client,
    tcp_server
  } con_type_e;

  typedef enum logic [1:0] {
    close_none,
    close_active,
    close_passive,
    close_reset
  } close_e;

  state_e    state, state_nxt;
  con_type_e con_type, con_type_nxt;
  close_e    close, close_nxt;
  logic      fin_acked, fin_acked_nxt; // peer acked our FIN before sending its own
  logic      tmo_hold, tmo_hold_nxt;   // no new open until the request is withdrawn
  logic      usr_dcn;
  logic      conn_ack;

  // a client closes on connect low, a server on listen low
  assign usr_dcn  = (con_type == tcp_client) ? !ctl.connect : !ctl.listen;
  assign conn_ack = evt.conn_hit && evt.ack && evt.ack_ok; // peer acks our last seq

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      state     <= closed_s;
      con_type  <= tcp_client;
      close     <= close_none;
      fin_acked <= 1'b0;
      tmo_hold  <= 1'b0;
    end else begin
      state     <= state_nxt;
      con_type  <= con_type_nxt;
      close     <= close_nxt;
      fin_acked <= fin_acked_nxt;
      tmo_hold  <= tmo_hold_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // next state and tcb updates
  always_comb begin
    state_nxt     = state;
    con_type_nxt  = con_type;
    close_nxt     = close;
    fin_acked_nxt = fin_acked;
    tmo_hold_nxt  = tmo_hold;
    tcb_op        = op_none;
    case (state)
      closed_s : begin
        close_nxt     = close_none;
        fin_acked_nxt = 1'b0;
        if (tmo_hold) begin
          if (!ctl.listen && !ctl.connect) tmo_hold_nxt = 1'b0;
        end else if (ctl.listen) begin
          con_type_nxt = tcp_server; // passive open
          state_nxt    = listen_s;
        end else if (ctl.connect) begin
          con_type_nxt = tcp_client; // active open
          tcb_op       = op_open_active;
          state_nxt    = send_syn_s;
        end
      end
      listen_s : begin
        if (!ctl.listen) begin
          state_nxt = closed_s;
        end else if (evt.syn && evt.loc_port_hit) begin
          tcb_op    = op_open_passive;
          state_nxt = send_syn_ack_s;
        end
      end
      send_syn_s : state_nxt = syn_sent_s;
      syn_sent_s : begin
        if (evt.conn_hit && evt.syn_ack) begin
          tcb_op    = op_syn_ack_rec;
          state_nxt = send_ack_open_s;
        end
      end
      send_syn_ack_s : state_nxt = syn_ack_sent_s;
      syn_ack_sent_s : begin
        if (conn_ack) begin // last step of the handshake
          tcb_op    = op_ack_rec;
          state_nxt = established_s;
        end
      end
      send_ack_open_s : state_nxt = established_s;
      established_s : begin
        if (usr_dcn) begin
          close_nxt = close_active;
          state_nxt = send_fin_s;
        end else if (evt.conn_hit && evt.rst) begin
          close_nxt = close_reset;
          state_nxt = send_rst_s;
        end else if (evt.conn_hit && evt.fin) begin
          close_nxt = close_passive;
          tcb_op    = op_fin_ack_inc; // peer FIN takes one seq
          state_nxt = send_last_ack_s;
        end else if (evt.conn_hit) begin
          tcb_op = op_update;
        end
      end
      send_fin_s : state_nxt = fin_sent_s;
      fin_sent_s : begin
        if (close == close_passive) begin
          if (conn_ack) state_nxt = closed_s; // our FIN acked, done
        end else if (evt.conn_hit && evt.fin && (fin_acked || conn_ack)) begin
          tcb_op    = op_fin_ack_inc;
          state_nxt = send_last_ack_s;
        end else if (conn_ack) begin
          fin_acked_nxt = 1'b1;
        end
      end
      send_last_ack_s : state_nxt = last_ack_sent_s;
      last_ack_sent_s : begin
        // passive side still owes its own FIN
        state_nxt = (close == close_passive) ? send_fin_s : closed_s;
      end
      send_rst_s : state_nxt = closed_s;
      default    : state_nxt = closed_s;
    endcase

    // connect or disconnect took too long
    if (tmr_exp) begin
      state_nxt    = closed_s;
      tcb_op       = op_none;
      tmo_hold_nxt = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // moore outputs
  always_comb begin
    case (state)
      closed_s        : status = tcp_closed;
      listen_s        : status = tcp_listening;
      send_syn_s,
      syn_sent_s,
      send_syn_ack_s,
      syn_ack_sent_s,
      send_ack_open_s : status = tcp_connecting;
      established_s   : status = tcp_connected;
      default         : status = tcp_disconnecting;
    endcase
  end

  always_comb begin
    case (state)
      send_syn_s      : send = send_syn;
      send_syn_ack_s  : send = send_syn_ack;
      send_ack_open_s,
      send_last_ack_s : send = send_ack;
      send_fin_s      : send = send_fin_ack;
      send_rst_s      : send = send_rst_ack;
      default         : send = send_none;
    endcase
  end

  // timer runs through both the handshake and the closure
  assign tmr_run = !(state inside {closed_s, listen_s, established_s});

endmodule

//--- tcp_conn_top.sv
`timescale 1ns/1ps

module tcp_conn_top #(
  parameter int          TIMEOUT_TICKS = 1000,
  parameter int          LOCAL_WND     = 4000,
  parameter int          LOCAL_SCL     = 8,
  parameter logic [31:0] ISN_POLY      = 32'hdeadbeef
) (
  input  logic                        clk,
  input  logic                        rst_rec,
  input  tcp_conn_pkg::tcp_ctl_t      ctl,
  input  tcp_conn_pkg::tcp_seg_strb_t rx_seg,
  output tcp_conn_pkg::tcp_seg_strb_t tx_seg,
  output tcp_conn_pkg::tcp_info_t     info
);
  import tcp_conn_pkg::*;

  tcp_evt_t    evt;
  tcp_tcb_t    tcb;
  tcp_status_e status;
  send_kind_e  send;
  tcb_op_e     tcb_op;
  logic        tmr_run;
  logic        tmr_exp;

  assign info = {status, tcb}; // field order of tcp_info_t follows tcp_tcb_t

  tcp_seg_classify classify0 (
    .clk      (clk),
    .rst_rec  (rst_rec),
    .rx_seg   (rx_seg),
    .loc_port (ctl.loc_port),
    .tcb      (tcb),
    .evt      (evt)
  );

  tcp_conn_fsm fsm0 (
    .clk     (clk),
    .rst_rec (rst_rec),
    .ctl     (ctl),
    .evt     (evt),
    .tmr_exp (tmr_exp),
    .status  (status),
    .send    (send),
    .tcb_op  (tcb_op),
    .tmr_run (tmr_run)
  );

  tcp_tcb_reg #(.ISN_POLY(ISN_POLY)) tcb0 (
    .clk     (clk),
    .rst_rec (rst_rec),
    .ctl     (ctl),
    .evt     (evt),
    .tcb_op  (tcb_op),
    .tcb     (tcb)
  );

  tcp_seg_build #(.LOCAL_WND(LOCAL_WND), .LOCAL_SCL(LOCAL_SCL)) build0 (
    .clk     (clk),
    .rst_rec (rst_rec),
    .send    (send),
    .tcb     (tcb),
    .tx_seg  (tx_seg)
  );

  tcp_conn_timer #(.TIMEOUT_TICKS(TIMEOUT_TICKS)) timer0 (
    .clk     (clk),
    .rst_rec (rst_rec),
    .run     (tmr_run),
    .exp     (tmr_exp)
  );

endmodule

//--- tb_tcp_conn.sv
`timescale 1ns/1ps

module tb_tcp_conn;
  import tcp_conn_pkg::*;

  localparam int TIMEOUT_TICKS = 64; // short, keeps the timeout case quick
  localparam int LOCAL_WND     = 4000;
  localparam int LOCAL_SCL     = 8;

  logic          clk;
  logic          rst_rec;
  tcp_ctl_t      ctl;
  tcp_seg_strb_t rx_seg;
  tcp_seg_strb_t tx_seg;
  tcp_info_t     info;

  // peer model state
  tcp_seg_t  rsp;         // last segment seen from the DUT
  tcp_num_t  loc_isn;     // DUT initial seq, taken from its SYN or SYN-ACK
  tcp_num_t  peer_seq;    // next seq the peer sends
  tcp_num_t  rem_ack_exp;
  tcp_scl_t  peer_scl;    // effective shift after the cap
  tcp_port_t l_port;
  tcp_port_t r_port;

  tcp_conn_top #(
    .TIMEOUT_TICKS (TIMEOUT_TICKS),
    .LOCAL_WND     (LOCAL_WND),
    .LOCAL_SCL     (LOCAL_SCL)
  ) dut0 (
    .clk     (clk),
    .rst_rec (rst_rec),
    .ctl     (ctl),
    .rx_seg  (rx_seg),
    .tx_seg  (tx_seg),
    .info    (info)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %h actual %h",
                          $time, name, exp, act));
    end
  endtask

  // one cycle, lands just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic tcp_port_t random_port();
    return tcp_port_t'($urandom_range(1024, 65535));
  endfunction

  task automatic send_seg(input tcp_port_t src, input tcp_port_t dst, input tcp_num_t seq,
                          input tcp_num_t ack, input logic [7:0] fl, input tcp_wnd_t wnd,
                          input logic opt, input tcp_scl_t scl);
    rx_seg.seg.src_port  = src;
    rx_seg.seg.dst_port  = dst;
    rx_seg.seg.seq_num   = seq;
    rx_seg.seg.ack_num   = ack;
    rx_seg.seg.flags.raw = fl;
    rx_seg.seg.wnd       = wnd;
    rx_seg.seg.scl_pres  = opt;
    rx_seg.seg.scl       = scl;
    rx_seg.seg.pld_len   = '0;
    rx_seg.val           = 1'b1;
    tick();
    rx_seg.val = 1'b0; // single cycle strobe
  endtask

  // captures the next strobe, then steps past it
  task automatic wait_tx(input int limit);
    int n;
    n = 0;
    while (!tx_seg.val) begin
      if (n >= limit) abort_run("timeout while waiting for a segment from the DUT");
      tick();
      n++;
    end
    rsp = tx_seg.seg;
    tick();
  endtask

  task automatic wait_status(input tcp_status_e st, input int limit);
    int n;
    n = 0;
    while (info.status != st) begin
      if (n >= limit) begin
        abort_run($sformatf("timeout while waiting for status %s", st.name()));
      end
      tick();
      n++;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      check_val("tx_seg.val", 32'd0, 32'(tx_seg.val));
      tick();
    end
  endtask

  // new connection, new pseudo random initial seq
  task automatic learn_isn();
    assert (rsp.seq_num !== loc_isn) else begin
      abort_run("initial sequence number did not change between connections");
    end
    loc_isn = rsp.seq_num;
  endtask

  task automatic check_rsp(input logic [7:0] fl, input tcp_num_t seq, input tcp_num_t ack);
    logic opt;
    opt = (fl & TCP_FLAG_SYN) != 8'h00; // scale option rides on SYN only
    check_val("tx_seg.flags", 32'(fl), 32'(rsp.flags.raw));
    check_val("tx_seg.src_port", 32'(l_port), 32'(rsp.src_port));
    check_val("tx_seg.dst_port", 32'(r_port), 32'(rsp.dst_port));
    check_val("tx_seg.seq_num", seq, rsp.seq_num);
    check_val("tx_seg.ack_num", ack, rsp.ack_num);
    check_val("tx_seg.wnd", LOCAL_WND, 32'(rsp.wnd));
    check_val("tx_seg.pld_len", 32'd0, 32'(rsp.pld_len));
    check_val("tx_seg.scl_pres", 32'(opt), 32'(rsp.scl_pres));
    if (opt) check_val("tx_seg.scl", LOCAL_SCL, 32'(rsp.scl));
  endtask

  // plain ack from the peer while established
  task automatic peer_update(input tcp_num_t ack, input tcp_wnd_t wnd);
    logic signed [31:0] dif;
    send_seg(r_port, l_port, peer_seq, ack, TCP_FLAG_ACK, wnd, 1'b0, 4'd0);
    tick();
    dif = ack - rem_ack_exp;
    if (dif > 0) rem_ack_exp = ack; // forward only, modulo 2^32
    check_val("info.rem_ack", rem_ack_exp, info.rem_ack);
    check_val("info.rem_wnd", {16'd0, wnd} << peer_scl, info.rem_wnd);
    check_val("tx_seg.val", 32'd0, 32'(tx_seg.val));
  endtask

  task automatic start_connect();
    l_port = random_port();
    r_port = random_port();
    ctl.loc_port = l_port;
    ctl.rem_port = r_port;
    ctl.connect  = 1'b1;
    wait_tx(8);
    learn_isn();
    check_rsp(TCP_FLAG_SYN, loc_isn, 32'd0);
    check_val("info.status", 32'(tcp_connecting), 32'(info.status));
    check_val("info.loc_port", 32'(l_port), 32'(info.loc_port));
    check_val("info.rem_port", 32'(r_port), 32'(info.rem_port));
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    rst_rec = 1'b1;
    ctl     = '0;
    rx_seg  = '0;
    void'($urandom(32'h53a6_b4d6));
    repeat (4) @(posedge clk);
    #1;
    rst_rec = 1'b0;
    check_val("tx_seg.val", 32'd0, 32'(tx_seg.val));
    check_val("info.status", 32'(tcp_closed), 32'(info.status));
    check_val("info.loc_seq", 32'd0, info.loc_seq);
    check_val("info.rem_wnd", 32'd0, info.rem_wnd);

    // active open, peer scale 3
    start_connect();
    peer_seq = $urandom;
    peer_scl = 4'd3;
    send_seg(r_port, l_port, peer_seq, loc_isn + 1, TCP_FLAG_SYN | TCP_FLAG_ACK,
             16'd1000, 1'b1, 4'd3);
    peer_seq = peer_seq + 1; // peer SYN takes one seq
    wait_tx(8);
    check_rsp(TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    wait_status(tcp_connected, 8);
    rem_ack_exp = loc_isn + 1;
    check_val("info.loc_ack", peer_seq, info.loc_ack);

    // rem_ack tracking, older acks are ignored
    peer_update(loc_isn + 101, 16'd2000);
    peer_update(loc_isn + 51, 16'd3000);
    peer_update(loc_isn + 301, 16'hffff);

    // active close
    ctl.connect = 1'b0;
    wait_tx(8);
    check_rsp(TCP_FLAG_FIN | TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    check_val("info.status", 32'(tcp_disconnecting), 32'(info.status));
    send_seg(r_port, l_port, peer_seq, loc_isn + 2, TCP_FLAG_ACK, 16'd1000, 1'b0, 4'd0);
    expect_quiet(4);
    send_seg(r_port, l_port, peer_seq, loc_isn + 2, TCP_FLAG_FIN | TCP_FLAG_ACK,
             16'd1000, 1'b0, 4'd0);
    peer_seq = peer_seq + 1;
    wait_tx(8);
    check_rsp(TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    wait_status(tcp_closed, 8);
    expect_quiet(6);

    ////////////////////////////////////////////////////////////
    // passive open, scale option 15 is capped to 14
    l_port = random_port();
    r_port = random_port();
    ctl.loc_port = l_port;
    ctl.rem_port = '0;
    ctl.listen   = 1'b1;
    wait_status(tcp_listening, 8);
    peer_seq = $urandom;
    send_seg(r_port, l_port ^ 16'h0001, peer_seq, 32'd0, TCP_FLAG_SYN, 16'd1000, 1'b1, 4'd15);
    expect_quiet(8); // wrong port, no reply
    check_val("info.status", 32'(tcp_listening), 32'(info.status));
    peer_scl = MAX_WND_SCL;
    send_seg(r_port, l_port, peer_seq, 32'd0, TCP_FLAG_SYN, 16'd1000, 1'b1, 4'd15);
    peer_seq = peer_seq + 1;
    wait_tx(8);
    learn_isn();
    check_rsp(TCP_FLAG_SYN | TCP_FLAG_ACK, loc_isn, peer_seq);
    rem_ack_exp = loc_isn + 1;
    send_seg(r_port, l_port, peer_seq, loc_isn + 1, TCP_FLAG_ACK, 16'd5, 1'b0, 4'd0);
    wait_status(tcp_connected, 8);
    check_val("info.loc_port", 32'(l_port), 32'(info.loc_port));
    check_val("info.rem_port", 32'(r_port), 32'(info.rem_port));
    check_val("info.loc_seq", loc_isn + 1, info.loc_seq);
    check_val("info.rem_ack", rem_ack_exp, info.rem_ack);
    check_val("info.rem_wnd", 32'd5 << 14, info.rem_wnd);
    peer_update(loc_isn - 39, 16'd7);

    // passive close, ACK then our own FIN
    send_seg(r_port, l_port, peer_seq, loc_isn + 1, TCP_FLAG_FIN | TCP_FLAG_ACK,
             16'd5, 1'b0, 4'd0);
    peer_seq = peer_seq + 1;
    wait_tx(8);
    check_rsp(TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    wait_tx(8);
    check_rsp(TCP_FLAG_FIN | TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    ctl.listen = 1'b0; // no reopen after close
    send_seg(r_port, l_port, peer_seq, loc_isn + 2, TCP_FLAG_ACK, 16'd5, 1'b0, 4'd0);
    wait_status(tcp_closed, 8);
    expect_quiet(6);

    ////////////////////////////////////////////////////////////
    // reset by the peer, no scale option
    start_connect();
    peer_seq = $urandom;
    peer_scl = 4'd0;
    send_seg(r_port, l_port, peer_seq, loc_isn + 1, TCP_FLAG_SYN | TCP_FLAG_ACK,
             16'd1000, 1'b0, 4'd9); // scl field ignored without the option
    peer_seq = peer_seq + 1;
    wait_tx(8);
    check_rsp(TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    wait_status(tcp_connected, 8);
    rem_ack_exp = loc_isn + 1;
    peer_update(loc_isn + 1, 16'd1234);
    send_seg(r_port, l_port, peer_seq, loc_isn + 1, TCP_FLAG_RST | TCP_FLAG_ACK,
             16'd0, 1'b0, 4'd0);
    tick();
    ctl.connect = 1'b0;
    wait_tx(8);
    check_rsp(TCP_FLAG_RST | TCP_FLAG_ACK, loc_isn + 1, peer_seq);
    wait_status(tcp_closed, 4);
    expect_quiet(6);

    ////////////////////////////////////////////////////////////
    // unanswered SYN times out
    start_connect();
    wait_status(tcp_closed, TIMEOUT_TICKS + 4);
    expect_quiet(20); // connect still high, engine holds off
    check_val("info.status", 32'(tcp_closed), 32'(info.status));
    ctl.connect = 1'b0;
    expect_quiet(4);
    check_val("info.status", 32'(tcp_closed), 32'(info.status));

    $display("all tests passed");
    $finish;
  end

endmodule

//--- build.f
tcp_conn_pkg.sv
tcp_conn_timer.sv
tcp_seg_classify.sv
tcp_tcb_reg.sv
tcp_seg_build.sv
tcp_conn_fsm.sv
tcp_conn_top.sv
tb_tcp_conn.sv
